//--- verilog/pwo_pkg.sv
/*
 * PWO engine shared definitions
 * Field constants for q = 8380417, the row memory geometry,
 * the vector types for coefficients, rows and row addresses,
 * and the operation and host select encodings.
 */

package pwo_pkg;

    // ====================
    // Field
    // ====================
    localparam logic [22:0] COEFF_Q    = 23'd8380417;
    localparam int          COEFF_W    = 24;
    // 2^23 mod q, used to fold the upper product bits back down
    localparam logic [12:0] COEFF_FOLD = 13'd8191;

    // ====================
    // Memory geometry
    // ====================
    localparam int LANES      = 4;
    localparam int N_COEFF    = 256;
    localparam int ROWS       = N_COEFF / LANES;
    localparam int ROW_ADDR_W = $clog2(ROWS);
    localparam int ROW_W      = LANES * COEFF_W;

    typedef logic [COEFF_W-1:0]    coeff_t;
    // Lane i sits at bits i*COEFF_W upward
    typedef logic [ROW_W-1:0]      row_t;
    typedef logic [ROW_ADDR_W-1:0] row_addr_t;

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_t;

    // Target memory of a host write
    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_B = 2'd1,
        SEL_C = 2'd2
    } host_sel_t;

endpackage

//--- verilog/pwo_row_ram.sv
/*
 * Row memory
 * One polynomial of ROWS rows, four coefficients per row.
 * One write port, one registered read port (1 cycle latency),
 * zeroize wipes the whole array and the read register.
 */

`timescale 1ns/100ps

module pwo_row_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  logic                we,
    input  pwo_pkg::row_addr_t  waddr,
    input  pwo_pkg::row_t       wdata,
    input  logic                re,
    input  pwo_pkg::row_addr_t  raddr,
    output pwo_pkg::row_t       rdata
);

    pwo_pkg::row_t mem [pwo_pkg::ROWS];

    // Write port, zeroize has priority over any write
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < pwo_pkg::ROWS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, holds its value while re is low
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- verilog/pwo_operand_feeder.sv
/*
 * Operand feeder
 * Walks the rows of one polynomial, issues the memory reads and
 * presents the operand rows to the lanes one cycle later.
 * In sampler mode a row is issued only on a sampler strobe.
 */

`timescale 1ns/100ps

module pwo_operand_feeder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  logic                start,
    input  pwo_pkg::pwo_mode_t  mode,
    input  logic                accumulate,
    input  logic                sampler_mode,
    input  logic                sampler_valid,
    input  pwo_pkg::row_t       sampler_data,
    input  logic                done,
    output logic                busy,
    output logic                rd_en,
    output pwo_pkg::row_addr_t  rd_addr,
    output logic                acc_rd_en,
    input  pwo_pkg::row_t       mem_b_rdata,
    output logic                op_valid,
    output pwo_pkg::row_addr_t  op_addr,
    output pwo_pkg::pwo_mode_t  op_mode,
    output pwo_pkg::row_t       op_b,
    output logic                op_c_en
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } feed_state_t;

    feed_state_t         state;
    pwo_pkg::row_addr_t  row_cnt;
    pwo_pkg::pwo_mode_t  mode_q;
    logic                acc_q;
    logic                smp_q;
    pwo_pkg::row_t       smp_row;
    logic                issue;

    // Memory mode issues every cycle, sampler mode waits for the strobe
    assign issue     = (state == RUN) && (!smp_q || sampler_valid);
    assign rd_en     = issue;
    assign rd_addr   = row_cnt;
    assign acc_rd_en = issue && acc_q;

    // Busy drops together with the done pulse from the writer
    assign busy = (state == RUN) || ((state == DRAIN) && !done);

    // ====================
    // Sequencing FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            state   <= IDLE;
            row_cnt <= '0;
            mode_q  <= pwo_pkg::PWO_MUL;
            acc_q   <= 1'b0;
            smp_q   <= 1'b0;
        end else if (start && !busy) begin
            state   <= RUN;
            row_cnt <= '0;
            mode_q  <= mode;
            acc_q   <= accumulate;
            smp_q   <= sampler_mode;
        end else begin
            case (state)
                RUN: begin
                    if (issue) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (row_cnt == pwo_pkg::row_addr_t'(pwo_pkg::ROWS - 1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Sampler row captured with its strobe, lines up with memory data
    always_ff @(posedge clk) begin
        if (zeroize) begin
            smp_row <= '0;
        end else if (sampler_valid) begin
            smp_row <= sampler_data;
        end
    end

    // ====================
    // Operand alignment
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            op_valid <= 1'b0;
            op_c_en  <= 1'b0;
        end else begin
            op_valid <= issue;
            op_c_en  <= acc_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        op_addr <= row_cnt;
        op_mode <= mode_q;
    end

    assign op_b = smp_q ? smp_row : mem_b_rdata;

endmodule

//--- verilog/pwo_coeff_lane.sv
/*
 * Coefficient lane
 * Two-stage pipeline on one coefficient modulo q.
 * Stage 1 multiplies, adds or subtracts, stage 2 adds the
 * old c when accumulate is set.
 */

`timescale 1ns/100ps

module pwo_coeff_lane (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  logic                in_valid,
    input  pwo_pkg::pwo_mode_t  in_mode,
    input  logic                in_acc,
    input  pwo_pkg::row_addr_t  in_addr,
    input  pwo_pkg::coeff_t     a,
    input  pwo_pkg::coeff_t     b,
    input  pwo_pkg::coeff_t     c,
    output logic                out_valid,
    output pwo_pkg::row_addr_t  out_addr,
    output pwo_pkg::coeff_t     res
);

    function automatic pwo_pkg::coeff_t add_mod(input pwo_pkg::coeff_t x,
                                                input pwo_pkg::coeff_t y);
        pwo_pkg::coeff_t s;
        s = x + y;
        return (s >= pwo_pkg::COEFF_Q) ? s - pwo_pkg::COEFF_Q : s;
    endfunction

    function automatic pwo_pkg::coeff_t sub_mod(input pwo_pkg::coeff_t x,
                                                input pwo_pkg::coeff_t y);
        return (x >= y) ? x - y : x + pwo_pkg::COEFF_Q - y;
    endfunction

    // q = 2^23 - 2^13 + 1, so the top bits fold back as hi * (2^13 - 1)
    function automatic pwo_pkg::coeff_t mul_mod(input logic [45:0] p);
        logic [36:0]     f1;
        logic [27:0]     f2;
        pwo_pkg::coeff_t f3;
        f1 = 37'(p[45:23]) * 37'(pwo_pkg::COEFF_FOLD) + 37'(p[22:0]);
        f2 = 28'(f1[36:23]) * 28'(pwo_pkg::COEFF_FOLD) + 28'(f1[22:0]);
        f3 = 24'(f2[27:23]) * 24'(pwo_pkg::COEFF_FOLD) + 24'(f2[22:0]);
        // Below 2q here, one correction is enough
        return (f3 >= pwo_pkg::COEFF_Q) ? f3 - pwo_pkg::COEFF_Q : f3;
    endfunction

    logic [45:0]         prod;
    pwo_pkg::coeff_t     s1_res_d;
    logic                s1_valid;
    logic                s1_acc;
    pwo_pkg::row_addr_t  s1_addr;
    pwo_pkg::coeff_t     s1_res;
    pwo_pkg::coeff_t     s1_c;

    assign prod = 46'(a) * 46'(b);

    always_comb begin
        case (in_mode)
            pwo_pkg::PWO_MUL: s1_res_d = mul_mod(prod);
            pwo_pkg::PWO_ADD: s1_res_d = add_mod(a, b);
            pwo_pkg::PWO_SUB: s1_res_d = sub_mod(a, b);
            default:          s1_res_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            s1_valid  <= 1'b0;
            s1_acc    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s1_acc    <= in_acc;
            out_valid <= s1_valid;
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        s1_res   <= s1_res_d;
        s1_c     <= c;
        s1_addr  <= in_addr;
        res      <= s1_acc ? add_mod(s1_res, s1_c) : s1_res;
        out_addr <= s1_addr;
    end

endmodule

//--- verilog/pwo_result_writer.sv
/*
 * Result writer
 * Registers the packed lane results as a write to memory C,
 * counts the rows written and pulses done one cycle after
 * the last row of the polynomial.
 */

`timescale 1ns/100ps

module pwo_result_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  logic                in_valid,
    input  pwo_pkg::row_addr_t  in_addr,
    input  pwo_pkg::row_t       lane_res,
    output logic                wr_en,
    output pwo_pkg::row_addr_t  wr_addr,
    output pwo_pkg::row_t       wr_data,
    output logic                done
);

    pwo_pkg::row_addr_t wr_cnt;

    // ====================
    // Row count and done
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            wr_en  <= 1'b0;
            wr_cnt <= '0;
            done   <= 1'b0;
        end else begin
            wr_en <= in_valid;
            done  <= 1'b0;
            if (wr_en) begin
                if (wr_cnt == pwo_pkg::row_addr_t'(pwo_pkg::ROWS - 1)) begin
                    wr_cnt <= '0;
                    done   <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_addr <= in_addr;
            wr_data <= lane_res;
        end
    end

endmodule

//--- verilog/pwo_top.sv
/*
 * PWO engine top level
 * Pointwise multiply, add or subtract of two polynomials mod q
 * with optional accumulate into C. Holds memories A, B and C,
 * the feeder, four lanes and the writer. The host port owns
 * the memories while the engine is idle.
 */

`timescale 1ns/100ps

module pwo_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zeroize,
    input  pwo_pkg::pwo_mode_t  mode,
    input  logic                accumulate,
    input  logic                start,
    input  logic                sampler_mode,
    input  logic                sampler_valid,
    input  pwo_pkg::row_t       sampler_data,
    input  logic                host_we,
    input  pwo_pkg::host_sel_t  host_sel,
    input  pwo_pkg::row_addr_t  host_waddr,
    input  pwo_pkg::row_t       host_wdata,
    input  pwo_pkg::row_addr_t  host_raddr,
    output pwo_pkg::row_t       host_rdata,
    output logic                busy,
    output logic                done
);

    logic                rd_en;
    pwo_pkg::row_addr_t  rd_addr;
    logic                acc_rd_en;
    logic                op_valid;
    pwo_pkg::row_addr_t  op_addr;
    pwo_pkg::pwo_mode_t  op_mode;
    pwo_pkg::row_t       op_a;
    pwo_pkg::row_t       op_b;
    pwo_pkg::row_t       op_c;
    logic                op_c_en;
    pwo_pkg::row_t       mem_b_rdata;
    pwo_pkg::row_t       mem_c_rdata;
    logic                res_valid;
    pwo_pkg::row_addr_t  res_addr;
    pwo_pkg::row_t       res_row;
    logic                wr_en;
    pwo_pkg::row_addr_t  wr_addr;
    pwo_pkg::row_t       wr_data;
    logic                a_we;
    logic                b_we;
    logic                c_we;
    logic                c_re;

    // ====================
    // Host and engine muxing
    // ====================
    assign a_we = !busy && host_we && (host_sel == pwo_pkg::SEL_A);
    assign b_we = !busy && host_we && (host_sel == pwo_pkg::SEL_B);
    assign c_we = busy ? wr_en : (host_we && (host_sel == pwo_pkg::SEL_C));
    // Idle C is read back continuously at the host address
    assign c_re = busy ? acc_rd_en : 1'b1;

    assign host_rdata = mem_c_rdata;
    assign op_c       = op_c_en ? mem_c_rdata : '0;

    pwo_row_ram u_mem_a (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .we(a_we), .waddr(host_waddr), .wdata(host_wdata),
        .re(rd_en), .raddr(rd_addr), .rdata(op_a)
    );

    pwo_row_ram u_mem_b (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .we(b_we), .waddr(host_waddr), .wdata(host_wdata),
        .re(rd_en), .raddr(rd_addr), .rdata(mem_b_rdata)
    );

    pwo_row_ram u_mem_c (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .we(c_we),
        .waddr(busy ? wr_addr : host_waddr),
        .wdata(busy ? wr_data : host_wdata),
        .re(c_re),
        .raddr(busy ? rd_addr : host_raddr),
        .rdata(mem_c_rdata)
    );

    pwo_operand_feeder u_feeder (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .start(start), .mode(mode), .accumulate(accumulate),
        .sampler_mode(sampler_mode), .sampler_valid(sampler_valid),
        .sampler_data(sampler_data), .done(done), .busy(busy),
        .rd_en(rd_en), .rd_addr(rd_addr), .acc_rd_en(acc_rd_en),
        .mem_b_rdata(mem_b_rdata),
        .op_valid(op_valid), .op_addr(op_addr), .op_mode(op_mode),
        .op_b(op_b), .op_c_en(op_c_en)
    );

    // ====================
    // Lanes
    // ====================
    for (genvar i = 0; i < pwo_pkg::LANES; i++) begin : gen_lane
        // Lane 0 carries valid and row address for the whole row
        if (i == 0) begin : gen_lead
            pwo_coeff_lane u_lane (
                .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
                .in_valid(op_valid), .in_mode(op_mode), .in_acc(op_c_en), .in_addr(op_addr),
                .a(op_a[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .b(op_b[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .c(op_c[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .out_valid(res_valid), .out_addr(res_addr),
                .res(res_row[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W])
            );
        end else begin : gen_follow
            pwo_coeff_lane u_lane (
                .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
                .in_valid(op_valid), .in_mode(op_mode), .in_acc(op_c_en), .in_addr(op_addr),
                .a(op_a[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .b(op_b[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .c(op_c[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W]),
                .out_valid(), .out_addr(),
                .res(res_row[i*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W])
            );
        end
    end

    pwo_result_writer u_writer (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .in_valid(res_valid), .in_addr(res_addr), .lane_res(res_row),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .done(done)
    );

endmodule

//--- testbench/pwo_properties.sv
/*
 * PWO engine control checks
 * Concurrent assertions on busy, done and the engine write
 * enable of memory C, bound into the top level.
 */

`timescale 1ns/100ps

module pwo_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                zeroize,
    input logic                busy,
    input logic                done,
    input logic                wr_en
);

    // ====================
    // Handshake
    // ====================
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    busy_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!busy && !done))
        else $error("busy or done high after reset");

    idle_after_zeroize: assert property (@(posedge clk) disable iff (!rst_n)
        zeroize |=> (!busy && !done))
        else $error("busy or done high after zeroize");

    // Busy falls in the done cycle
    busy_low_at_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy)
        else $error("busy still high while done pulses");

    // ====================
    // Memory C ownership
    // ====================
    no_engine_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !wr_en)
        else $error("engine write to memory C while idle");

endmodule

//--- testbench/pwo_tb.sv
/*
 * PWO engine testbench
 * Loads A, B and C through the host port, runs multiply, add,
 * subtract, accumulate and sampler operations, zeroize and a
 * start while busy, and reads C back against a reference model.
 */

`timescale 1ns/100ps

module pwo_tb;

    localparam int CLK_PERIOD   = 4;
    // Bound on one wait for done with sampler gaps included
    localparam int DONE_LIMIT   = 8 * pwo_pkg::ROWS;
    // One phase loads A and B, runs and reads C back with some margin
    localparam int PHASE_CYCLES = 4 * pwo_pkg::ROWS + 32;
    localparam int TEST_CYCLES  = 8 * PHASE_CYCLES + 4 * pwo_pkg::ROWS;
    localparam int WATCHDOG_NS  = 20 * TEST_CYCLES * CLK_PERIOD;

    logic                clk;
    logic                rst_n;
    logic                zeroize;
    pwo_pkg::pwo_mode_t  mode;
    logic                accumulate;
    logic                start;
    logic                sampler_mode;
    logic                sampler_valid;
    pwo_pkg::row_t       sampler_data;
    logic                host_we;
    pwo_pkg::host_sel_t  host_sel;
    pwo_pkg::row_addr_t  host_waddr;
    pwo_pkg::row_t       host_wdata;
    pwo_pkg::row_addr_t  host_raddr;
    pwo_pkg::row_t       host_rdata;
    logic                busy;
    logic                done;

    // Reference polynomials indexed by row * LANES + lane
    pwo_pkg::coeff_t     ref_a [pwo_pkg::N_COEFF];
    pwo_pkg::coeff_t     ref_b [pwo_pkg::N_COEFF];
    pwo_pkg::coeff_t     exp_c [pwo_pkg::N_COEFF];

    logic [31:0]         rng_state;
    logic                read_req;
    logic                cmp_valid;
    pwo_pkg::row_addr_t  cmp_row;
    int                  done_count;
    int                  cmp_count;
    int                  cmp_errors;
    int                  check_errors;
    int                  other_failures;
    int                  cycles;
    int                  done_before;

    pwo_top u_dut (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize),
        .mode(mode), .accumulate(accumulate), .start(start),
        .sampler_mode(sampler_mode), .sampler_valid(sampler_valid),
        .sampler_data(sampler_data),
        .host_we(host_we), .host_sel(host_sel), .host_waddr(host_waddr),
        .host_wdata(host_wdata), .host_raddr(host_raddr), .host_rdata(host_rdata),
        .busy(busy), .done(done)
    );

    bind pwo_top pwo_properties u_props (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .busy(busy), .done(done),
        .wr_en(wr_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pwo_pkg::coeff_t random_coeff();
        rng_state = xorshift32(rng_state);
        return pwo_pkg::coeff_t'(rng_state % 32'(pwo_pkg::COEFF_Q));
    endfunction

    // Field edges 0, q-1 and 1 for k up to 2 and a random value above
    function automatic pwo_pkg::coeff_t edge_value(input int k);
        case (k)
            0:       return '0;
            1:       return pwo_pkg::coeff_t'(pwo_pkg::COEFF_Q) - 24'd1;
            2:       return 24'd1;
            default: return random_coeff();
        endcase
    endfunction

    function automatic pwo_pkg::coeff_t expected_coeff(input pwo_pkg::pwo_mode_t op,
                                                       input pwo_pkg::coeff_t a,
                                                       input pwo_pkg::coeff_t b,
                                                       input pwo_pkg::coeff_t c_old,
                                                       input logic acc);
        logic [63:0] q;
        logic [63:0] r;
        q = 64'(pwo_pkg::COEFF_Q);
        case (op)
            pwo_pkg::PWO_MUL: r = (64'(a) * 64'(b)) % q;
            pwo_pkg::PWO_ADD: r = (64'(a) + 64'(b)) % q;
            pwo_pkg::PWO_SUB: r = (64'(a) + q - 64'(b)) % q;
            default:          r = '0;
        endcase
        if (acc) begin
            r = (r + 64'(c_old)) % q;
        end
        return pwo_pkg::coeff_t'(r);
    endfunction

    function automatic pwo_pkg::row_t ref_row(input pwo_pkg::host_sel_t sel, input int r);
        pwo_pkg::row_t row;
        int            idx;
        row = '0;
        for (int l = 0; l < pwo_pkg::LANES; l++) begin
            idx = r * pwo_pkg::LANES + l;
            case (sel)
                pwo_pkg::SEL_A: row[l*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W] = ref_a[idx];
                pwo_pkg::SEL_B: row[l*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W] = ref_b[idx];
                default:        row[l*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W] = exp_c[idx];
            endcase
        end
        return row;
    endfunction

    task automatic fill_random(input pwo_pkg::host_sel_t sel);
        for (int i = 0; i < pwo_pkg::N_COEFF; i++) begin
            case (sel)
                pwo_pkg::SEL_A: ref_a[i] = random_coeff();
                pwo_pkg::SEL_B: ref_b[i] = random_coeff();
                default:        exp_c[i] = random_coeff();
            endcase
        end
    endtask

    task automatic update_expected(input pwo_pkg::pwo_mode_t op, input logic acc);
        for (int i = 0; i < pwo_pkg::N_COEFF; i++) begin
            exp_c[i] = expected_coeff(op, ref_a[i], ref_b[i], exp_c[i], acc);
        end
    endtask

    // ====================
    // Host port and engine control
    // ====================
    task automatic write_poly(input pwo_pkg::host_sel_t sel);
        for (int r = 0; r < pwo_pkg::ROWS; r++) begin
            @(negedge clk);
            host_we    = 1'b1;
            host_sel   = sel;
            host_waddr = pwo_pkg::row_addr_t'(r);
            host_wdata = ref_row(sel, r);
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic start_engine(input pwo_pkg::pwo_mode_t op, input logic acc,
                                input logic smp);
        @(negedge clk);
        mode         = op;
        accumulate   = acc;
        sampler_mode = smp;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(output int n);
        n = 0;
        while (done !== 1'b1 && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("Timeout: done did not arrive within %0d cycles", DONE_LIMIT);
            other_failures++;
        end else if (busy !== 1'b0) begin
            $display("[ERROR] %0t: busy still high in the done cycle", $time);
            check_errors++;
        end
    endtask

    task automatic run_memory_op(input pwo_pkg::pwo_mode_t op, input logic acc);
        start_engine(op, acc, 1'b0);
        wait_done(cycles);
        // Counted from the edge that samples start
        if (cycles != pwo_pkg::ROWS + 4) begin
            $display("[ERROR] %0t: start to done took %0d cycles, expected %0d",
                     $time, cycles, pwo_pkg::ROWS + 4);
            check_errors++;
        end
        update_expected(op, acc);
    endtask

    task automatic stream_sampler_rows();
        int gap;
        for (int r = 0; r < pwo_pkg::ROWS; r++) begin
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state[1:0]);
            repeat (gap) begin
                @(negedge clk);
                sampler_valid = 1'b0;
            end
            @(negedge clk);
            if (done === 1'b1) begin
                $display("[ERROR] %0t: done before sampler row %0d was sent", $time, r);
                check_errors++;
            end
            sampler_valid = 1'b1;
            sampler_data  = ref_row(pwo_pkg::SEL_B, r);
        end
        @(negedge clk);
        sampler_valid = 1'b0;
    endtask

    // Requests every C row for the compare process
    task automatic check_c_rows();
        for (int r = 0; r < pwo_pkg::ROWS; r++) begin
            @(negedge clk);
            read_req   = 1'b1;
            host_raddr = pwo_pkg::row_addr_t'(r);
        end
        @(negedge clk);
        read_req = 1'b0;
        @(negedge clk);
    endtask

    // ====================
    // Compare and done count
    // ====================
    always @(posedge clk) begin
        cmp_valid <= read_req;
        cmp_row   <= host_raddr;
    end

    always @(negedge clk) begin : compare_c
        pwo_pkg::coeff_t got;
        pwo_pkg::coeff_t want;
        if (cmp_valid === 1'b1) begin
            for (int l = 0; l < pwo_pkg::LANES; l++) begin
                got  = host_rdata[l*pwo_pkg::COEFF_W +: pwo_pkg::COEFF_W];
                want = exp_c[int'(cmp_row) * pwo_pkg::LANES + l];
                cmp_count++;
                if (got !== want) begin
                    $display("[ERROR] %0t: C row %0d lane %0d expected %0d got %0d",
                             $time, cmp_row, l, want, got);
                    cmp_errors++;
                end
                if (32'(got) >= 32'(pwo_pkg::COEFF_Q)) begin
                    $display("[ERROR] %0t: C row %0d lane %0d value %0d not below q",
                             $time, cmp_row, l, got);
                    cmp_errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        zeroize       = 1'b0;
        mode          = pwo_pkg::PWO_MUL;
        accumulate    = 1'b0;
        start         = 1'b0;
        sampler_mode  = 1'b0;
        sampler_valid = 1'b0;
        sampler_data  = '0;
        host_we       = 1'b0;
        host_sel      = pwo_pkg::SEL_A;
        host_waddr    = '0;
        host_wdata    = '0;
        host_raddr    = '0;
        read_req      = 1'b0;
        rng_state     = 32'ha8032e64;
        done_count     = 0;
        cmp_count      = 0;
        cmp_errors     = 0;
        check_errors   = 0;
        other_failures = 0;
        for (int i = 0; i < pwo_pkg::N_COEFF; i++) begin
            exp_c[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("[ERROR] %0t: busy or done high after reset", $time);
            check_errors++;
        end

        $display("Test 1: pointwise multiply");
        fill_random(pwo_pkg::SEL_A);
        fill_random(pwo_pkg::SEL_B);
        write_poly(pwo_pkg::SEL_A);
        write_poly(pwo_pkg::SEL_B);
        run_memory_op(pwo_pkg::PWO_MUL, 1'b0);
        check_c_rows();

        $display("Test 2: add and subtract with edge operands");
        for (int i = 0; i < pwo_pkg::N_COEFF; i++) begin
            ref_a[i] = edge_value(i % 4);
            ref_b[i] = edge_value((i / 4) % 4);
        end
        write_poly(pwo_pkg::SEL_A);
        write_poly(pwo_pkg::SEL_B);
        run_memory_op(pwo_pkg::PWO_ADD, 1'b0);
        check_c_rows();
        run_memory_op(pwo_pkg::PWO_SUB, 1'b0);
        check_c_rows();

        $display("Test 3: multiply with accumulate");
        fill_random(pwo_pkg::SEL_A);
        fill_random(pwo_pkg::SEL_B);
        fill_random(pwo_pkg::SEL_C);
        write_poly(pwo_pkg::SEL_A);
        write_poly(pwo_pkg::SEL_B);
        write_poly(pwo_pkg::SEL_C);
        run_memory_op(pwo_pkg::PWO_MUL, 1'b1);
        check_c_rows();

        $display("Test 4: sampler mode");
        fill_random(pwo_pkg::SEL_A);
        fill_random(pwo_pkg::SEL_B);
        write_poly(pwo_pkg::SEL_A);
        done_before = done_count;
        start_engine(pwo_pkg::PWO_MUL, 1'b0, 1'b1);
        if (busy !== 1'b1) begin
            $display("[ERROR] %0t: busy low after start in sampler mode", $time);
            check_errors++;
        end
        stream_sampler_rows();
        wait_done(cycles);
        repeat (8) @(negedge clk);
        if (done_count - done_before != 1) begin
            $display("[ERROR] %0t: expected 1 done pulse, counted %0d",
                     $time, done_count - done_before);
            check_errors++;
        end
        update_expected(pwo_pkg::PWO_MUL, 1'b0);
        check_c_rows();

        $display("Test 5: zeroize");
        @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("[ERROR] %0t: busy or done high after zeroize", $time);
            check_errors++;
        end
        for (int i = 0; i < pwo_pkg::N_COEFF; i++) begin
            exp_c[i] = '0;
        end
        check_c_rows();

        $display("Test 6: start while busy");
        fill_random(pwo_pkg::SEL_A);
        fill_random(pwo_pkg::SEL_B);
        write_poly(pwo_pkg::SEL_A);
        write_poly(pwo_pkg::SEL_B);
        done_before = done_count;
        start_engine(pwo_pkg::PWO_MUL, 1'b0, 1'b0);
        repeat (8) @(negedge clk);
        // A second start with other settings must change nothing
        mode       = pwo_pkg::PWO_ADD;
        accumulate = 1'b1;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(cycles);
        repeat (pwo_pkg::ROWS + 8) @(negedge clk);
        if (done_count - done_before != 1) begin
            $display("[ERROR] %0t: expected 1 done pulse, counted %0d",
                     $time, done_count - done_before);
            check_errors++;
        end
        update_expected(pwo_pkg::PWO_MUL, 1'b0);
        check_c_rows();

        if (cmp_count == 0) begin
            $display("No C coefficient was compared during the run");
            other_failures++;
        end
        $display("Summary: %0d compared, errors %0d compare, %0d check, %0d other",
                 cmp_count, cmp_errors, check_errors, other_failures);
        if (cmp_errors == 0 && check_errors == 0 && other_failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/pwo_pkg.sv
verilog/pwo_row_ram.sv
verilog/pwo_operand_feeder.sv
verilog/pwo_coeff_lane.sv
verilog/pwo_result_writer.sv
verilog/pwo_top.sv
testbench/pwo_properties.sv
testbench/pwo_tb.sv

//--- Makefile
# Verilator build and run of the PWO engine testbench

VERILATOR  ?= verilator
TOP        ?= pwo_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run build lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
